// ==== tests/cd_link_sva.sv ====
////////////////////////////////////////////////////////////
// CD link protocol assertions
// Bound into the top level to watch the CDC write strobes,
// the command toggle and the status receive window
////////////////////////////////////////////////////////////

`default_nettype none

module cd_link_sva (
	input wire                     clk_sys,
	input wire                     rst_n_i,
	input wire cd_pkg::host_word_t cd_out_i,
	input wire cd_pkg::host_word_t cd_in_o,
	input wire                     cdd_send_i,
	input wire                     cdd_rec_o,
	input wire                     cdc_dat_wr_o,
	input wire                     cdc_sc_wr_o
);

	int         assert_fail_cnt = 0;
	logic       toggle_prev;
	logic [7:0] chg_hist;

	// Host toggle changes seen over the last eight edges
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			toggle_prev <= 1'b0;
			chg_hist    <= '0;
		end else begin
			toggle_prev <= cd_out_i[cd_pkg::HOST_TOGGLE_BIT];
			chg_hist    <= {chg_hist[6:0], cd_out_i[cd_pkg::HOST_TOGGLE_BIT] != toggle_prev};
		end
	end

	a_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		!(cdc_dat_wr_o && cdc_sc_wr_o))
	else begin
		$error("sector data and subcode strobes high together");
		assert_fail_cnt++;
	end

	// Toggle of the outgoing word follows a send rise by one cycle
	a_cmd_toggle: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		$changed(cd_in_o[cd_pkg::HOST_TOGGLE_BIT]) |->
			($past(cdd_send_i) && !$past(cdd_send_i, 2)))
	else begin
		$error("command toggle changed without a send rise");
		assert_fail_cnt++;
	end

	a_rec_bounded: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		cdd_rec_o [*9] |-> (chg_hist != '0))
	else begin
		$error("status strobe held past its window without a new toggle");
		assert_fail_cnt++;
	end

endmodule

bind cd_link cd_link_sva i_cd_link_sva (
	.clk_sys      (clk_sys),
	.rst_n_i      (rst_n_i),
	.cd_out_i     (cd_out_i),
	.cd_in_o      (cd_in_o),
	.cdd_send_i   (cdd_send_i),
	.cdd_rec_o    (cdd_rec_o),
	.cdc_dat_wr_o (cdc_dat_wr_o),
	.cdc_sc_wr_o  (cdc_sc_wr_o)
);

`default_nettype wire

// ==== tests/cd_link_tb.sv ====
////////////////////////////////////////////////////////////
// CD link testbench
// Directed tests of drive status receive, command send and
// sector data download, with LFSR stimulus and a timeout
////////////////////////////////////////////////////////////

`default_nettype none

module cd_link_tb;

	localparam logic [15:0] LFSR_SEED = 16'd85;
	// Tests take under 200 cycles, so this leaves ample margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic                        clk_sys;
	logic                        rst_n_i;
	cd_pkg::host_word_t          cd_out;
	cd_pkg::host_word_t          cd_in;
	logic                        ioctl_download;
	logic [cd_pkg::IOCTL_INDEX_W-1:0] ioctl_index;
	logic                        ioctl_wr;
	cd_pkg::cdc_data_t           ioctl_data;
	cd_pkg::cdd_cmd_t            cdd_comm;
	logic                        cdd_send;
	cd_pkg::cdd_stat_t           cdd_stat;
	logic                        cdd_dm;
	logic                        cdd_rec;
	cd_pkg::cdc_data_t           cdc_data;
	logic                        cdc_dat_wr;
	logic                        cdc_sc_wr;

	logic [15:0]                 lfsr_state;
	int                          cycle_cnt = 0;
	logic                        host_toggle;
	logic                        cmd_toggle;
	cd_pkg::cdd_status_t         exp_status;
	cd_pkg::host_word_t          exp_word;

	cd_link i_cd_link (
		.clk_sys          (clk_sys),
		.rst_n_i          (rst_n_i),
		.cd_out_i         (cd_out),
		.cd_in_o          (cd_in),
		.ioctl_download_i (ioctl_download),
		.ioctl_index_i    (ioctl_index),
		.ioctl_wr_i       (ioctl_wr),
		.ioctl_data_i     (ioctl_data),
		.cdd_comm_i       (cdd_comm),
		.cdd_send_i       (cdd_send),
		.cdd_stat_o       (cdd_stat),
		.cdd_dm_o         (cdd_dm),
		.cdd_rec_o        (cdd_rec),
		.cdc_data_o       (cdc_data),
		.cdc_dat_wr_o     (cdc_dat_wr),
		.cdc_sc_wr_o      (cdc_sc_wr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "run stopped by timeout");
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[62:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Advance to just after the next edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
		if (i_cd_link.i_cd_link_sva.assert_fail_cnt != 0) begin
			$display("A bound assertion on cd_link failed");
			$display("TEST FAILED");
			$fatal(1, "run stopped on assertion failure");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_status(input cd_pkg::cdd_status_t act,
				input cd_pkg::cdd_status_t exp, input string name);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s = %h, expected %h", $time, name, act, exp);
			$display("TEST FAILED");
			$fatal(1, "stopping on mismatch");
		end
	endtask

	task automatic check_host_word(input cd_pkg::host_word_t act,
				input cd_pkg::host_word_t exp, input string name);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s = %h, expected %h", $time, name, act, exp);
			$display("TEST FAILED");
			$fatal(1, "stopping on mismatch");
		end
	endtask

	task automatic check_beat(input cd_pkg::cdc_beat_t act,
				input cd_pkg::cdc_beat_t exp, input string name);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s = %h, expected %h", $time, name, act, exp);
			$display("TEST FAILED");
			$fatal(1, "stopping on mismatch");
		end
	endtask

	task automatic check_bit(input logic act, input logic exp, input string name);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s = %b, expected %b", $time, name, act, exp);
			$display("TEST FAILED");
			$fatal(1, "stopping on mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Drive status
	////////////////////////////////////////////////////////////

	// Random status and data mode with the toggle flipped
	task automatic new_status();
		logic [63:0] rnd;
		rnd = random_bits(48);
		host_toggle = ~host_toggle;
		cd_out = {host_toggle, rnd[47:0]};
		exp_status.stat = rnd[cd_pkg::CDD_STAT_W-1:0];
		exp_status.dm   = rnd[cd_pkg::HOST_DM_BIT];
	endtask

	task automatic expect_status_window(input int high_cycles);
		cd_pkg::cdd_status_t act;
		for (int i = 0; i < high_cycles; i++) begin
			next_cycle();
			act.stat = cdd_stat;
			act.dm   = cdd_dm;
			check_status(act, exp_status, "cdd_stat_o/cdd_dm_o");
			check_bit(cdd_rec, 1'b1, "cdd_rec_o");
		end
		next_cycle();
		check_bit(cdd_rec, 1'b0, "cdd_rec_o");
	endtask

	task automatic test_reset_state();
		check_bit(cdd_rec, 1'b0, "cdd_rec_o");
		check_bit(cdc_dat_wr, 1'b0, "cdc_dat_wr_o");
		check_bit(cdc_sc_wr, 1'b0, "cdc_sc_wr_o");
		check_host_word(cd_in, '0, "cd_in_o");
	endtask

	task automatic test_status_receive();
		logic [63:0]         rnd;
		cd_pkg::cdd_status_t act;
		new_status();
		expect_status_window(8);
		// Other bits move while the toggle stays
		rnd = random_bits(41);
		cd_out[cd_pkg::HOST_DM_BIT:0] = rnd[cd_pkg::HOST_DM_BIT:0];
		repeat (4) begin
			next_cycle();
			act.stat = cdd_stat;
			act.dm   = cdd_dm;
			check_status(act, exp_status, "cdd_stat_o/cdd_dm_o");
			check_bit(cdd_rec, 1'b0, "cdd_rec_o");
		end
	endtask

	task automatic test_repeated_status();
		new_status();
		repeat (3) begin
			next_cycle();
			check_bit(cdd_rec, 1'b1, "cdd_rec_o");
		end
		new_status();
		expect_status_window(8);
	endtask

	////////////////////////////////////////////////////////////
	// Drive commands
	////////////////////////////////////////////////////////////

	task automatic send_command();
		logic [63:0] rnd;
		rnd = random_bits(cd_pkg::CDD_CMD_W);
		cdd_comm = rnd[cd_pkg::CDD_CMD_W-1:0];
		cdd_send = 1'b1;
		cmd_toggle = ~cmd_toggle;
		exp_word = '0;
		exp_word[cd_pkg::CDD_CMD_W-1:0] = rnd[cd_pkg::CDD_CMD_W-1:0];
		exp_word[cd_pkg::HOST_TOGGLE_BIT] = cmd_toggle;
		next_cycle();
		check_host_word(cd_in, exp_word, "cd_in_o");
	endtask

	task automatic test_command_send();
		logic [63:0] rnd;
		send_command();
		// New command must not go out while send stays high
		rnd = random_bits(cd_pkg::CDD_CMD_W);
		cdd_comm = rnd[cd_pkg::CDD_CMD_W-1:0];
		repeat (4) begin
			next_cycle();
			check_host_word(cd_in, exp_word, "cd_in_o");
		end
		cdd_send = 1'b0;
		next_cycle();
		check_host_word(cd_in, exp_word, "cd_in_o");
		send_command();
		cdd_send = 1'b0;
		next_cycle();
		check_host_word(cd_in, exp_word, "cd_in_o");
	endtask

	////////////////////////////////////////////////////////////
	// Sector data download
	////////////////////////////////////////////////////////////

	task automatic write_and_check(input logic [cd_pkg::IOCTL_INDEX_W-1:0] index,
				input logic download);
		logic [63:0]       rnd;
		logic              hit;
		cd_pkg::cdc_beat_t exp_beat;
		cd_pkg::cdc_beat_t act;
		rnd = random_bits(cd_pkg::CDC_DATA_W);
		exp_beat.data = rnd[cd_pkg::CDC_DATA_W-1:0];
		exp_beat.sub  = (index[5:0] == cd_pkg::CDC_SUB_INDEX);
		hit = download && ((index[5:0] == cd_pkg::CDC_DAT_INDEX) || exp_beat.sub);
		ioctl_download = download;
		ioctl_index    = index;
		ioctl_data     = exp_beat.data;
		ioctl_wr       = 1'b1;
		for (int i = 0; i < cd_pkg::STRETCH_CYCLES; i++) begin
			next_cycle();
			ioctl_wr = 1'b0;
			if (hit) begin
				act.data = cdc_data;
				act.sub  = cdc_sc_wr;
				check_beat(act, exp_beat, "cdc_data_o/cdc_sc_wr_o");
				check_bit(cdc_dat_wr, ~exp_beat.sub, "cdc_dat_wr_o");
			end else begin
				check_bit(cdc_dat_wr, 1'b0, "cdc_dat_wr_o");
				check_bit(cdc_sc_wr, 1'b0, "cdc_sc_wr_o");
			end
		end
		next_cycle();
		check_bit(cdc_dat_wr, 1'b0, "cdc_dat_wr_o");
		check_bit(cdc_sc_wr, 1'b0, "cdc_sc_wr_o");
	endtask

	task automatic test_download();
		write_and_check(8'd2, 1'b1);
		write_and_check(8'd3, 1'b1);
		// Upper index bits are not compared
		write_and_check(8'hC3, 1'b1);
		write_and_check(8'd1, 1'b1);
		write_and_check(8'd2, 1'b0);
		write_and_check(8'd3, 1'b0);
		ioctl_download = 1'b0;
		ioctl_index    = '0;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst_n_i        = 1'b0;
		cd_out         = '0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_data     = '0;
		cdd_comm       = '0;
		cdd_send       = 1'b0;
		lfsr_state     = LFSR_SEED;
		host_toggle    = 1'b0;
		cmd_toggle     = 1'b0;
		exp_status     = '0;
		exp_word       = '0;
		repeat (16) @(posedge clk_sys);
		#2;
		rst_n_i = 1'b1;
		next_cycle();

		test_reset_state();
		test_status_receive();
		test_repeated_status();
		test_command_send();
		test_download();

		next_cycle();
		if (i_cd_link.i_cd_link_sva.assert_fail_cnt == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "run ended with assertion failures");
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cd_link.sv ====
////////////////////////////////////////////////////////////
// CD link top level
// Joins the host CD drive emulation channel and download
// stream to the Mega CD drive and CDC interfaces
////////////////////////////////////////////////////////////

`default_nettype none

module cd_link (
	input  wire                               clk_sys,
	input  wire                               rst_n_i,

	// Host CD words
	input  wire  cd_pkg::host_word_t          cd_out_i,
	output cd_pkg::host_word_t                cd_in_o,

	// Host download channel
	input  wire                               ioctl_download_i,
	input  wire  [cd_pkg::IOCTL_INDEX_W-1:0]  ioctl_index_i,
	input  wire                               ioctl_wr_i,
	input  wire  cd_pkg::cdc_data_t           ioctl_data_i,

	// Mega CD drive interface
	input  wire  cd_pkg::cdd_cmd_t            cdd_comm_i,
	input  wire                               cdd_send_i,
	output cd_pkg::cdd_stat_t                 cdd_stat_o,
	output logic                              cdd_dm_o,
	output logic                              cdd_rec_o,

	// Mega CD CDC interface
	output cd_pkg::cdc_data_t                 cdc_data_o,
	output logic                              cdc_dat_wr_o,
	output logic                              cdc_sc_wr_o
);

	cd_pkg::cdd_status_t cdd_status;

	////////////////////////////////////////////////////////////
	// Drive status and commands
	////////////////////////////////////////////////////////////

	cdd_host_port i_cdd_host_port (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.cd_out_i     (cd_out_i),
		.cd_in_o      (cd_in_o),
		.cdd_comm_i   (cdd_comm_i),
		.cdd_send_i   (cdd_send_i),
		.cdd_status_o (cdd_status),
		.cdd_rec_o    (cdd_rec_o)
	);

	// Unpack latched status
	assign cdd_stat_o = cdd_status.stat;
	assign cdd_dm_o   = cdd_status.dm;

	////////////////////////////////////////////////////////////
	// Sector data and subcode
	////////////////////////////////////////////////////////////

	cdc_download_port i_cdc_download_port (
		.clk_sys          (clk_sys),
		.rst_n_i          (rst_n_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_data_i     (ioctl_data_i),
		.cdc_data_o       (cdc_data_o),
		.cdc_dat_wr_o     (cdc_dat_wr_o),
		.cdc_sc_wr_o      (cdc_sc_wr_o)
	);

endmodule

`default_nettype wire

// ==== verilog/cd_pkg.sv ====
////////////////////////////////////////////////////////////
// CD link shared definitions
// Widths, host word bit positions, download indices,
// strobe stretch length and the payload types that
// travel between the host channel and the Mega CD side
////////////////////////////////////////////////////////////

`default_nettype none

package cd_pkg;

	////////////////////////////////////////////////////////////
	// Drive status and command words
	////////////////////////////////////////////////////////////

	localparam int CDD_STAT_W      = 40;
	localparam int CDD_CMD_W       = 40;
	localparam int HOST_WORD_W     = 49;
	localparam int HOST_TOGGLE_BIT = 48;
	// Data-mode flag sits just above the status in the host word
	localparam int HOST_DM_BIT     = 40;

	// Strobe stretch, counter sized to hold the full count
	localparam int STRETCH_CYCLES  = 8;
	localparam int STRETCH_CNT_W   = $clog2(STRETCH_CYCLES + 1);

	////////////////////////////////////////////////////////////
	// Host download channel
	////////////////////////////////////////////////////////////

	localparam int CDC_DATA_W         = 16;
	localparam int IOCTL_INDEX_W      = 8;
	localparam int IOCTL_INDEX_MASK_W = 6;

	localparam logic [IOCTL_INDEX_MASK_W-1:0] CDC_DAT_INDEX = 6'd2;
	localparam logic [IOCTL_INDEX_MASK_W-1:0] CDC_SUB_INDEX = 6'd3;

	typedef logic [HOST_WORD_W-1:0] host_word_t;
	typedef logic [CDD_STAT_W-1:0]  cdd_stat_t;
	typedef logic [CDD_CMD_W-1:0]   cdd_cmd_t;
	typedef logic [CDC_DATA_W-1:0]  cdc_data_t;

	// Latched drive status as seen by the subsystem
	typedef struct packed {
		logic      dm;
		cdd_stat_t stat;
	} cdd_status_t;

	// One download write, flagged when it carries subcode
	typedef struct packed {
		logic      sub;
		cdc_data_t data;
	} cdc_beat_t;

endpackage

`default_nettype wire

// ==== verilog/cdc_download_port.sv ====
////////////////////////////////////////////////////////////
// CD sector data download port
// Picks sector data and subcode writes out of the host
// download stream and stretches each write strobe
////////////////////////////////////////////////////////////

`default_nettype none

module cdc_download_port (
	input  wire                               clk_sys,
	input  wire                               rst_n_i,
	input  wire                               ioctl_download_i,
	input  wire  [cd_pkg::IOCTL_INDEX_W-1:0]  ioctl_index_i,
	input  wire                               ioctl_wr_i,
	input  wire  cd_pkg::cdc_data_t           ioctl_data_i,
	output cd_pkg::cdc_data_t                 cdc_data_o,
	output logic                              cdc_dat_wr_o,
	output logic                              cdc_sc_wr_o
);

	logic [cd_pkg::IOCTL_INDEX_MASK_W-1:0] index_low;
	logic                                  dat_sel;
	logic                                  sub_sel;
	logic                                  beat_wr;
	cd_pkg::cdc_beat_t                     beat_in;
	cd_pkg::cdc_beat_t                     beat_q;
	logic                                  beat_stb;

	// Upper index bits are ignored
	assign index_low = ioctl_index_i[cd_pkg::IOCTL_INDEX_MASK_W-1:0];

	assign dat_sel = ioctl_download_i && (index_low == cd_pkg::CDC_DAT_INDEX);
	assign sub_sel = ioctl_download_i && (index_low == cd_pkg::CDC_SUB_INDEX);
	assign beat_wr = ioctl_wr_i && (dat_sel || sub_sel);

	always_comb begin
		beat_in.sub  = sub_sel;
		beat_in.data = ioctl_data_i;
	end

	// Channel is latched with the data
	strobe_latch #(
		.payload_t (cd_pkg::cdc_beat_t)
	) i_beat_latch (
		.clk_sys   (clk_sys),
		.rst_n_i   (rst_n_i),
		.event_i   (beat_wr),
		.payload_i (beat_in),
		.payload_o (beat_q),
		.strobe_o  (beat_stb)
	);

	// Steer the stretched strobe
	assign cdc_data_o   = beat_q.data;
	assign cdc_dat_wr_o = beat_stb & ~beat_q.sub;
	assign cdc_sc_wr_o  = beat_stb & beat_q.sub;

endmodule

`default_nettype wire

// ==== verilog/cdd_host_port.sv ====
////////////////////////////////////////////////////////////
// CD drive host port
// Toggle-bit exchange with the host drive emulation:
// status words come in on a flip of the host toggle,
// commands go out with a flip of our own toggle
////////////////////////////////////////////////////////////

`default_nettype none

module cdd_host_port (
	input  wire                      clk_sys,
	input  wire                      rst_n_i,
	// Host side
	input  wire  cd_pkg::host_word_t cd_out_i,
	output cd_pkg::host_word_t       cd_in_o,
	// Subsystem side
	input  wire  cd_pkg::cdd_cmd_t   cdd_comm_i,
	input  wire                      cdd_send_i,
	output cd_pkg::cdd_status_t      cdd_status_o,
	output logic                     cdd_rec_o
);

	logic                toggle_last;
	logic                toggle_chg;
	cd_pkg::cdd_status_t status_in;
	logic                send_q;
	logic                send_rise;

	////////////////////////////////////////////////////////////
	// Status from host
	////////////////////////////////////////////////////////////

	// Host holds the other bits steady while it flips the toggle
	assign toggle_chg = cd_out_i[cd_pkg::HOST_TOGGLE_BIT] != toggle_last;

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			toggle_last <= 1'b0;
		end else begin
			toggle_last <= cd_out_i[cd_pkg::HOST_TOGGLE_BIT];
		end
	end

	// Status and data-mode slices
	always_comb begin
		status_in.stat = cd_out_i[cd_pkg::CDD_STAT_W-1:0];
		status_in.dm   = cd_out_i[cd_pkg::HOST_DM_BIT];
	end

	strobe_latch #(
		.payload_t (cd_pkg::cdd_status_t)
	) i_status_latch (
		.clk_sys   (clk_sys),
		.rst_n_i   (rst_n_i),
		.event_i   (toggle_chg),
		.payload_i (status_in),
		.payload_o (cdd_status_o),
		.strobe_o  (cdd_rec_o)
	);

	////////////////////////////////////////////////////////////
	// Commands to host
	////////////////////////////////////////////////////////////

	// Send is a level, only its rise counts
	assign send_rise = cdd_send_i & ~send_q;

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			send_q <= 1'b0;
		end else begin
			send_q <= cdd_send_i;
		end
	end

	// Command zero-extended into the word, then toggle flipped
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cd_in_o <= '0;
		end else if (send_rise) begin
			cd_in_o <= cd_pkg::host_word_t'(cdd_comm_i);
			cd_in_o[cd_pkg::HOST_TOGGLE_BIT] <= ~cd_in_o[cd_pkg::HOST_TOGGLE_BIT];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/strobe_latch.sv ====
////////////////////////////////////////////////////////////
// Strobe latch
// Registers a payload on an event and holds a strobe high
// for a fixed number of cycles; a new event reloads both
////////////////////////////////////////////////////////////

`default_nettype none

module strobe_latch #(
	parameter type payload_t = logic
) (
	input  wire      clk_sys,
	input  wire      rst_n_i,
	input  wire      event_i,
	input  wire      payload_t payload_i,
	output payload_t payload_o,
	output logic     strobe_o
);

	logic [cd_pkg::STRETCH_CNT_W-1:0] cnt;

	// Payload capture
	always_ff @(posedge clk_sys) begin
		if (event_i) begin
			payload_o <= payload_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Stretch counter
	////////////////////////////////////////////////////////////

	// Loaded on every event, so a late event restarts the window
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt <= '0;
		end else if (event_i) begin
			cnt <= cd_pkg::STRETCH_CNT_W'(cd_pkg::STRETCH_CYCLES);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// High while count remains, i.e. STRETCH_CYCLES edges
	assign strobe_o = (cnt != '0);

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/cd_pkg.sv
verilog/strobe_latch.sv
verilog/cdd_host_port.sv
verilog/cdc_download_port.sv
verilog/cd_link.sv
tests/cd_link_sva.sv
tests/cd_link_tb.sv
